/* filelist.f */
hdl/rv_exec_pkg.sv
hdl/reg_file.sv
hdl/instr_decoder.sv
hdl/alu.sv
hdl/pc_unit.sv
hdl/exec_core.sv
tb/tb_clock.sv
tb/exec_core_tb.sv

/* Bender.yml */
package:
  name: rv_exec

sources:
  - hdl/rv_exec_pkg.sv
  - hdl/reg_file.sv
  - hdl/instr_decoder.sv
  - hdl/alu.sv
  - hdl/pc_unit.sv
  - hdl/exec_core.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/exec_core_tb.sv

/* tb/exec_core_tb.sv */
`timescale 1ns/1ps

module exec_core_tb
    import rv_exec_pkg::*;
();

    typedef struct packed {
        word_t     instr;
        logic      wb_valid;
        reg_addr_t wb_rd;
        word_t     wb_data;
        logic      wb_over;
        logic      wb_nega;
        logic      illegal;
        word_t     pc;
    } entry_t;

    logic      clk;
    logic      reset;
    logic      valid;
    word_t     instr;
    word_t     pc;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      wb_over;
    logic      wb_nega;
    logic      illegal;

    entry_t stim_q[$];
    word_t  shadow_regs [32];
    word_t  shadow_pc;
    word_t  exp_pc;
    logic   last_valid;
    int     last_idx;
    int     value_errors;
    int     timeout_errors;

    tb_clock tb_clock_i (
        .o_clk (clk)
    );

    exec_core exec_core_i (
        .i_clk      (clk),
        .i_reset    (reset),
        .i_valid    (valid),
        .i_instr    (instr),
        .o_pc       (pc),
        .o_wb_valid (wb_valid),
        .o_wb_rd    (wb_rd),
        .o_wb_data  (wb_data),
        .o_wb_over  (wb_over),
        .o_wb_nega  (wb_nega),
        .o_illegal  (illegal)
    );

    ////////////////////////////////////////////////////////////
    // instruction encoders
    ////////////////////////////////////////////////////////////

    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic reg_addr_t src_reg();
        return reg_addr_t'($urandom_range(1, 6));
    endfunction

    function automatic reg_addr_t dst_reg();
        return reg_addr_t'($urandom_range(9, 15));
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic logic add_over(word_t x, word_t y);
        word_t s;
        s = x + y;
        return (x[31] == y[31]) && (s[31] != x[31]);
    endfunction

    function automatic logic sub_over(word_t x, word_t y);
        word_t d;
        d = x - y;
        return (x[31] != y[31]) && (d[31] != x[31]);
    endfunction

    // compares give all ones when true
    function automatic word_t op_result(logic [2:0] f3, logic alt, word_t x, word_t y);
        case (f3)
            3'd0:    return alt ? x - y : x + y;
            3'd1:    return x << y[4:0];
            3'd2:    return ($signed(x) < $signed(y)) ? '1 : '0;
            3'd3:    return (x < y) ? '1 : '0;
            3'd4:    return x ^ y;
            3'd5:    return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    task automatic add_instr(input word_t w);
        entry_t       e;
        word_t        a;
        word_t        b;
        word_t        imm_i;
        word_t        res;
        word_t        next_pc;
        logic         wr;
        logic         cond;
        logic         alt;
        logic [2:0]   f3;
        logic [6:0]   f7;
        a = shadow_regs[w[19:15]];
        b = shadow_regs[w[24:20]];
        f3 = w[14:12];
        f7 = w[31:25];
        imm_i = {{20{w[31]}}, w[31:20]};
        e.instr = w;
        e.illegal = 1'b0;
        e.wb_over = 1'b0;
        res = '0;
        wr = 1'b0;
        cond = 1'b0;
        next_pc = shadow_pc + 32'd4;
        case (w[6:0])
            OP_LUI: begin
                res = {w[31:12], 12'h000};
                wr = 1'b1;
            end
            OP_AUIPC: begin
                res = shadow_pc + {w[31:12], 12'h000};
                e.wb_over = add_over(shadow_pc, {w[31:12], 12'h000});
                wr = 1'b1;
            end
            OP_JAL: begin
                next_pc = shadow_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                wr = 1'b1;
            end
            OP_JALR: begin
                e.illegal = (f3 != 3'd0);
                res = (a + imm_i) & ~32'd1;
                next_pc = res;
                wr = 1'b1;
            end
            OP_BRANCH: begin
                case (f3)
                    3'd0:    cond = (a == b);
                    3'd1:    cond = (a != b);
                    3'd4:    cond = ($signed(a) < $signed(b));
                    3'd5:    cond = ($signed(a) >= $signed(b));
                    3'd6:    cond = (a < b);
                    3'd7:    cond = (a >= b);
                    default: e.illegal = 1'b1;
                endcase
                res = cond ? '1 : '0;
                if (cond) begin
                    next_pc = shadow_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            OP_OP_IMM: begin
                alt = (f3 == 3'd5) && f7[5];
                if (f3 == 3'd1) begin
                    e.illegal = (f7 != 7'h00);
                end else if (f3 == 3'd5) begin
                    e.illegal = (f7 != 7'h00) && (f7 != 7'h20);
                end
                res = op_result(f3, alt, a, imm_i);
                e.wb_over = (f3 == 3'd0) && add_over(a, imm_i);
                wr = 1'b1;
            end
            OP_OP: begin
                alt = f7[5];
                if (f7 == 7'h20) begin
                    e.illegal = (f3 != 3'd0) && (f3 != 3'd5);
                end else begin
                    e.illegal = (f7 != 7'h00);
                end
                res = op_result(f3, alt, a, b);
                if (f3 == 3'd0) begin
                    e.wb_over = alt ? sub_over(a, b) : add_over(a, b);
                end
                wr = 1'b1;
            end
            default: e.illegal = 1'b1;
        endcase
        if (e.illegal) begin
            res = '0;
            wr = 1'b0;
            e.wb_over = 1'b0;
            next_pc = shadow_pc + 32'd4;
        end
        e.wb_nega = res[31];
        e.wb_rd = w[11:7];
        e.wb_valid = wr && (w[11:7] != 5'd0);
        // jumps link the return address
        e.wb_data = ((w[6:0] == OP_JAL) || (w[6:0] == OP_JALR)) ? shadow_pc + 32'd4 : res;
        if (e.wb_valid) begin
            shadow_regs[w[11:7]] = e.wb_data;
        end
        shadow_pc = next_pc;
        e.pc = next_pc;
        stim_q.push_back(e);
    endtask

    task automatic load_const(input reg_addr_t rd, input word_t v);
        logic [19:0] hi;
        hi = v[31:12] + v[11];
        add_instr({hi, rd, 7'(OP_LUI)});
        add_instr(enc_i(v[11:0], rd, 3'd0, rd, OP_OP_IMM));
    endtask

    task automatic build_program();
        logic [2:0] br_f3 [6];
        br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        for (int r = 1; r <= 6; r++) begin
            load_const(reg_addr_t'(r), $urandom);
        end
        load_const(5'd7, 32'h7fff_ffff);
        load_const(5'd8, 32'h0000_0001);
        add_instr(enc_r(7'h00, 5'd8, 5'd7, 3'd0, 5'd9, OP_OP));
        add_instr(enc_r(7'h20, 5'd8, 5'd9, 3'd0, 5'd10, OP_OP));
        add_instr(enc_r(7'h20, 5'd6, 5'd9, 3'd5, 5'd11, OP_OP));
        repeat (3) begin
            for (int f = 0; f < 8; f++) begin
                add_instr(enc_r(7'h00, src_reg(), src_reg(), 3'(f), dst_reg(), OP_OP));
                add_instr(enc_i((f == 1 || f == 5) ? {7'h00, 5'($urandom)} : 12'($urandom),
                                src_reg(), 3'(f), dst_reg(), OP_OP_IMM));
            end
            add_instr(enc_r(7'h20, src_reg(), src_reg(), 3'd0, dst_reg(), OP_OP));
            add_instr(enc_r(7'h20, src_reg(), src_reg(), 3'd5, dst_reg(), OP_OP));
            add_instr(enc_i({7'h20, 5'($urandom)}, src_reg(), 3'd5, dst_reg(), OP_OP_IMM));
            add_instr({20'($urandom), dst_reg(), 7'(OP_LUI)});
            add_instr({20'($urandom), dst_reg(), 7'(OP_AUIPC)});
        end
        // equal and unequal operands give every branch both outcomes
        foreach (br_f3[k]) begin
            add_instr(enc_b(13'($urandom) & 13'h1ffc, 5'd1, 5'd1, br_f3[k]));
            add_instr(enc_b(13'($urandom) & 13'h1ffc, 5'd3, 5'd2, br_f3[k]));
            add_instr(enc_b(13'($urandom) & 13'h1ffc, 5'd2, 5'd3, br_f3[k]));
        end
        add_instr(enc_j(21'($urandom) & 21'h1ffffc, dst_reg()));
        add_instr(enc_j(21'($urandom) & 21'h1ffffc, 5'd0));
        add_instr(enc_i(12'($urandom), src_reg(), 3'd0, dst_reg(), OP_JALR));
        add_instr(enc_i(12'h7ff, src_reg(), 3'd0, dst_reg(), OP_JALR));
        add_instr(enc_i(12'd5, 5'd1, 3'd0, 5'd0, OP_OP_IMM));
        add_instr(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd9, OP_OP));
        add_instr(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd10, OP_OP));
        add_instr({25'($urandom), 7'b0000011});
        add_instr(enc_r(7'h01, 5'd1, 5'd2, 3'd0, 5'd9, OP_OP));
        add_instr(enc_r(7'h20, 5'd1, 5'd2, 3'd4, 5'd9, OP_OP));
        add_instr(enc_i({7'h20, 5'd3}, 5'd1, 3'd1, 5'd9, OP_OP_IMM));
        add_instr(enc_b(13'h0010, 5'd1, 5'd2, 3'd2));
        add_instr(enc_i(12'h004, 5'd1, 3'd1, 5'd9, OP_JALR));
    endtask

    ////////////////////////////////////////////////////////////
    // compare tasks and run control
    ////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // outputs of the previous slot are stable at the falling edge
    task automatic check_outputs();
        entry_t e;
        if (last_valid) begin
            e = stim_q[last_idx];
            check_bit("o_wb_valid", e.wb_valid, wb_valid);
            if (e.wb_valid) begin
                check_reg("o_wb_rd", e.wb_rd, wb_rd);
                check_word("o_wb_data", e.wb_data, wb_data);
            end
            check_bit("o_wb_over", e.wb_over, wb_over);
            check_bit("o_wb_nega", e.wb_nega, wb_nega);
            check_bit("o_illegal", e.illegal, illegal);
            check_word("o_pc", e.pc, pc);
            exp_pc = e.pc;
        end else begin
            check_bit("o_wb_valid", 1'b0, wb_valid);
            check_bit("o_illegal", 1'b0, illegal);
            check_word("o_pc", exp_pc, pc);
        end
    endtask

    // a gap carries a legal write to a source register that must not land
    task automatic apply_slot(input logic use_entry, input int idx);
        @(posedge clk);
        valid <= use_entry;
        instr <= use_entry ? stim_q[idx].instr :
                 enc_i(12'($urandom), src_reg(), 3'd0, src_reg(), OP_OP_IMM);
        @(negedge clk);
        check_outputs();
        last_valid = use_entry;
        last_idx = idx;
    endtask

    task automatic finish_run();
        $display("value errors: %0d, timeout errors: %0d", value_errors, timeout_errors);
        if ((value_errors == 0) && (timeout_errors == 0)) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        int n;
        void'($urandom(29142));
        value_errors = 0;
        timeout_errors = 0;
        reset = 1'b1;
        valid = 1'b0;
        instr = '0;
        for (int r = 0; r < 32; r++) begin
            shadow_regs[r] = '0;
        end
        shadow_pc = RESET_PC;
        exp_pc = RESET_PC;
        last_valid = 1'b0;
        last_idx = 0;
        build_program();
        for (n = 0; n < 16; n++) begin
            @(posedge clk);
        end
        reset <= 1'b0;
        n = 0;
        @(negedge clk);
        while ((pc !== RESET_PC) && (n < 8)) begin
            @(negedge clk);
            n++;
        end
        if (pc !== RESET_PC) begin
            timeout_errors++;
            $display("timed out waiting for the PC to come out of reset");
        end else begin
            check_bit("o_wb_valid", 1'b0, wb_valid);
            check_bit("o_illegal", 1'b0, illegal);
            check_bit("o_wb_over", 1'b0, wb_over);
            check_bit("o_wb_nega", 1'b0, wb_nega);
            foreach (stim_q[i]) begin
                if ($urandom_range(0, 3) == 0) begin
                    apply_slot(1'b0, 0);
                end
                apply_slot(1'b1, i);
            end
            apply_slot(1'b0, 0);
            apply_slot(1'b0, 0);
        end
        finish_run();
    end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic o_clk
);

    // 100 ns period
    initial begin
        o_clk = 1'b0;
        forever begin
            #50 o_clk = ~o_clk;
        end
    end

endmodule

/* hdl/exec_core.sv */
`timescale 1ns/1ps

module exec_core
    import rv_exec_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_valid,
    input  word_t     i_instr,
    output word_t     o_pc,
    output logic      o_wb_valid,
    output reg_addr_t o_wb_rd,
    output word_t     o_wb_data,
    output logic      o_wb_over,
    output logic      o_wb_nega,
    output logic      o_illegal
);

    reg_addr_t  w_rs1_addr;
    reg_addr_t  w_rs2_addr;
    reg_addr_t  w_rd_addr;
    alu_type_e  w_alu_type;
    logic       w_a_sel_pc;
    logic       w_a_sel_zero;
    logic       w_b_sel_imm;
    word_t      w_imm;
    jump_kind_e w_jump_kind;
    logic       w_rd_we;
    logic       w_illegal;

    word_t      w_rs1_data;
    word_t      w_rs2_data;
    word_t      w_op_a;
    word_t      w_op_b;
    word_t      w_alu_res;
    logic       w_alu_zero;
    logic       w_alu_over;
    logic       w_alu_nega;
    word_t      w_pc;
    word_t      w_pc_plus4;
    word_t      w_wb_data;
    logic       w_wb_fire;

    instr_decoder instr_decoder_i (
        .i_instr      (i_instr),
        .o_rs1_addr   (w_rs1_addr),
        .o_rs2_addr   (w_rs2_addr),
        .o_rd_addr    (w_rd_addr),
        .o_alu_type   (w_alu_type),
        .o_a_sel_pc   (w_a_sel_pc),
        .o_a_sel_zero (w_a_sel_zero),
        .o_b_sel_imm  (w_b_sel_imm),
        .o_imm        (w_imm),
        .o_jump_kind  (w_jump_kind),
        .o_rd_we      (w_rd_we),
        .o_illegal    (w_illegal)
    );

    reg_file reg_file_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rs1_addr (w_rs1_addr),
        .i_rs2_addr (w_rs2_addr),
        .o_rs1_data (w_rs1_data),
        .o_rs2_data (w_rs2_data),
        .i_we       (i_valid & w_rd_we),
        .i_rd_addr  (w_rd_addr),
        .i_rd_data  (w_wb_data)
    );

    ////////////////////////////////////////////////////////////
    // operand and write-back selection
    ////////////////////////////////////////////////////////////

    assign w_op_a = w_a_sel_zero ? '0 : (w_a_sel_pc ? w_pc : w_rs1_data);
    assign w_op_b = w_b_sel_imm ? w_imm : w_rs2_data;

    alu alu_i (
        .i_type     (w_alu_type),
        .i_rs1_data (w_op_a),
        .i_rs2_data (w_op_b),
        .o_res      (w_alu_res),
        .o_zero     (w_alu_zero),
        .o_over     (w_alu_over),
        .o_nega     (w_alu_nega)
    );

    pc_unit pc_unit_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_jump_kind   (w_jump_kind),
        .i_alu_zero    (w_alu_zero),
        .i_alu_res     (w_alu_res),
        .i_imm         (w_imm),
        .o_pc          (w_pc),
        .o_pc_plus4    (w_pc_plus4),
        .o_pc_next_dbg ()
    );

    // jumps link the return address instead of the ALU result
    assign w_wb_data = ((w_jump_kind == JUMP_JAL) || (w_jump_kind == JUMP_JALR)) ?
                       w_pc_plus4 : w_alu_res;
    assign w_wb_fire = i_valid && w_rd_we && (w_rd_addr != '0);

    assign o_pc = w_pc;

    ////////////////////////////////////////////////////////////
    // registered write-back outputs
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_valid <= 1'b0;
            o_illegal  <= 1'b0;
            o_wb_over  <= 1'b0;
            o_wb_nega  <= 1'b0;
        end else begin
            o_wb_valid <= w_wb_fire;
            o_illegal  <= i_valid && w_illegal;
            if (i_valid) begin
                o_wb_over <= w_alu_over;
                o_wb_nega <= w_alu_nega;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_wb_rd   <= w_rd_addr;
            o_wb_data <= w_wb_data;
        end
    end

endmodule

/* hdl/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit
    import rv_exec_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_valid,
    input  jump_kind_e i_jump_kind,
    input  logic       i_alu_zero,
    input  word_t      i_alu_res,
    input  word_t      i_imm,
    output word_t      o_pc,
    output word_t      o_pc_plus4,
    output word_t      o_pc_next_dbg
);

    word_t r_pc;
    word_t w_pc_imm;
    word_t w_pc_next;

    assign o_pc       = r_pc;
    assign o_pc_plus4 = r_pc + 32'd4;
    assign w_pc_imm   = r_pc + i_imm;

    // a branch is taken when the compare result is all ones
    always_comb begin
        case (i_jump_kind)
            JUMP_BRANCH: w_pc_next = i_alu_zero ? o_pc_plus4 : w_pc_imm;
            JUMP_JAL:    w_pc_next = w_pc_imm;
            JUMP_JALR:   w_pc_next = i_alu_res;
            default:     w_pc_next = o_pc_plus4;
        endcase
    end

    assign o_pc_next_dbg = w_pc_next;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_pc <= RESET_PC;
        end else if (i_valid) begin
            r_pc <= w_pc_next;
        end
    end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu
    import rv_exec_pkg::*;
(
    input  alu_type_e i_type,
    input  word_t     i_rs1_data,
    input  word_t     i_rs2_data,
    output word_t     o_res,
    output logic      o_zero,
    output logic      o_over,
    output logic      o_nega
);

    logic [4 : 0] w_shamt;
    logic         w_lt_s;
    logic         w_lt_u;
    logic         w_eq;
    word_t        w_sum;
    logic         w_rs1_sign;
    logic         w_rs2_sign;
    logic         w_res_sign;

    // RV32 shifts only look at the low five bits
    assign w_shamt = i_rs2_data[4 : 0];

    assign w_lt_s = $signed(i_rs1_data) < $signed(i_rs2_data);
    assign w_lt_u = i_rs1_data < i_rs2_data;
    assign w_eq   = i_rs1_data == i_rs2_data;
    assign w_sum  = i_rs1_data + i_rs2_data;

    always_comb begin
        case (i_type)
            ALU_SLL:  o_res = i_rs1_data << w_shamt;
            ALU_SRL:  o_res = i_rs1_data >> w_shamt;
            ALU_SRA:  o_res = word_t'($signed(i_rs1_data) >>> w_shamt);
            ALU_ADD:  o_res = w_sum;
            ALU_SUB:  o_res = i_rs1_data - i_rs2_data;
            ALU_XOR:  o_res = i_rs1_data ^ i_rs2_data;
            ALU_OR:   o_res = i_rs1_data | i_rs2_data;
            ALU_AND:  o_res = i_rs1_data & i_rs2_data;
            ALU_SLT:  o_res = {DATA_WIDTH{w_lt_s}};
            ALU_SLTU: o_res = {DATA_WIDTH{w_lt_u}};
            ALU_BEQ:  o_res = {DATA_WIDTH{w_eq}};
            ALU_BNE:  o_res = {DATA_WIDTH{~w_eq}};
            ALU_BLT:  o_res = {DATA_WIDTH{w_lt_s}};
            ALU_BGE:  o_res = {DATA_WIDTH{~w_lt_s}};
            ALU_BLTU: o_res = {DATA_WIDTH{w_lt_u}};
            ALU_BGEU: o_res = {DATA_WIDTH{~w_lt_u}};
            ALU_JALR: o_res = {w_sum[DATA_WIDTH - 1 : 1], 1'b0};
            default:  o_res = '0;
        endcase
    end

    assign o_zero = (o_res == '0);

    assign w_rs1_sign = i_rs1_data[DATA_WIDTH - 1];
    assign w_rs2_sign = i_rs2_data[DATA_WIDTH - 1];
    assign w_res_sign = o_res[DATA_WIDTH - 1];

    // add overflows when both signs agree and the result differs,
    // subtract when the signs differ and the result leaves rs1's sign
    assign o_over = ((i_type == ALU_ADD) && (w_rs1_sign == w_rs2_sign)
                                         && (w_res_sign != w_rs1_sign)) ||
                    ((i_type == ALU_SUB) && (w_rs1_sign != w_rs2_sign)
                                         && (w_res_sign != w_rs1_sign));
    assign o_nega = w_res_sign;

endmodule

/* hdl/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder
    import rv_exec_pkg::*;
(
    input  word_t      i_instr,
    output reg_addr_t  o_rs1_addr,
    output reg_addr_t  o_rs2_addr,
    output reg_addr_t  o_rd_addr,
    output alu_type_e  o_alu_type,
    output logic       o_a_sel_pc,
    output logic       o_a_sel_zero,
    output logic       o_b_sel_imm,
    output word_t      o_imm,
    output jump_kind_e o_jump_kind,
    output logic       o_rd_we,
    output logic       o_illegal
);

    logic [2 : 0] w_funct3;
    logic [6 : 0] w_funct7;
    word_t        w_imm_i;
    word_t        w_imm_u;
    word_t        w_imm_b;
    word_t        w_imm_j;

    assign w_funct3 = i_instr[14 : 12];
    assign w_funct7 = i_instr[31 : 25];

    assign o_rs1_addr = i_instr[19 : 15];
    assign o_rs2_addr = i_instr[24 : 20];
    assign o_rd_addr  = i_instr[11 : 7];

    assign w_imm_i = {{20{i_instr[31]}}, i_instr[31 : 20]};
    assign w_imm_u = {i_instr[31 : 12], 12'h000};
    assign w_imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                      i_instr[30 : 25], i_instr[11 : 8], 1'b0};
    assign w_imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19 : 12],
                      i_instr[20], i_instr[30 : 21], 1'b0};

    always_comb begin
        o_alu_type   = ALU_NONE;
        o_a_sel_pc   = 1'b0;
        o_a_sel_zero = 1'b0;
        o_b_sel_imm  = 1'b0;
        o_imm        = w_imm_i;
        o_jump_kind  = JUMP_NONE;
        o_rd_we      = 1'b0;
        o_illegal    = 1'b0;

        case (opcode_e'(i_instr[6 : 0]))
            OP_LUI: begin
                o_alu_type   = ALU_ADD;
                o_a_sel_zero = 1'b1;
                o_b_sel_imm  = 1'b1;
                o_imm        = w_imm_u;
                o_rd_we      = 1'b1;
            end
            OP_AUIPC: begin
                o_alu_type  = ALU_ADD;
                o_a_sel_pc  = 1'b1;
                o_b_sel_imm = 1'b1;
                o_imm       = w_imm_u;
                o_rd_we     = 1'b1;
            end
            OP_JAL: begin
                o_imm       = w_imm_j;
                o_jump_kind = JUMP_JAL;
                o_rd_we     = 1'b1;
            end
            OP_JALR: begin
                o_alu_type  = ALU_JALR;
                o_b_sel_imm = 1'b1;
                o_jump_kind = JUMP_JALR;
                o_rd_we     = 1'b1;
                o_illegal   = (w_funct3 != 3'b000);
            end
            OP_BRANCH: begin
                o_imm       = w_imm_b;
                o_jump_kind = JUMP_BRANCH;
                case (w_funct3)
                    3'b000:  o_alu_type = ALU_BEQ;
                    3'b001:  o_alu_type = ALU_BNE;
                    3'b100:  o_alu_type = ALU_BLT;
                    3'b101:  o_alu_type = ALU_BGE;
                    3'b110:  o_alu_type = ALU_BLTU;
                    3'b111:  o_alu_type = ALU_BGEU;
                    default: o_illegal  = 1'b1;
                endcase
            end
            OP_OP_IMM: begin
                o_b_sel_imm = 1'b1;
                o_rd_we     = 1'b1;
                case (w_funct3)
                    3'b000: o_alu_type = ALU_ADD;
                    3'b010: o_alu_type = ALU_SLT;
                    3'b011: o_alu_type = ALU_SLTU;
                    3'b100: o_alu_type = ALU_XOR;
                    3'b110: o_alu_type = ALU_OR;
                    3'b111: o_alu_type = ALU_AND;
                    3'b001: begin
                        o_alu_type = ALU_SLL;
                        o_illegal  = (w_funct7 != 7'b0000000);
                    end
                    default: begin
                        // shift right immediate, funct7 picks arithmetic or logical
                        o_alu_type = w_funct7[5] ? ALU_SRA : ALU_SRL;
                        o_illegal  = (w_funct7 != 7'b0000000) && (w_funct7 != 7'b0100000);
                    end
                endcase
            end
            OP_OP: begin
                o_rd_we = 1'b1;
                case (w_funct3)
                    3'b000:  o_alu_type = w_funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001:  o_alu_type = ALU_SLL;
                    3'b010:  o_alu_type = ALU_SLT;
                    3'b011:  o_alu_type = ALU_SLTU;
                    3'b100:  o_alu_type = ALU_XOR;
                    3'b101:  o_alu_type = w_funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  o_alu_type = ALU_OR;
                    default: o_alu_type = ALU_AND;
                endcase
                // only SUB and SRA may use the alternate funct7
                if (w_funct7 == 7'b0100000) begin
                    o_illegal = (w_funct3 != 3'b000) && (w_funct3 != 3'b101);
                end else begin
                    o_illegal = (w_funct7 != 7'b0000000);
                end
            end
            default: begin
                o_illegal = 1'b1;
            end
        endcase

        if (o_illegal) begin
            o_alu_type  = ALU_NONE;
            o_jump_kind = JUMP_NONE;
            o_rd_we     = 1'b0;
        end
    end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file
    import rv_exec_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    input  reg_addr_t i_rs1_addr,
    input  reg_addr_t i_rs2_addr,
    output word_t     o_rs1_data,
    output word_t     o_rs2_data,
    input  logic      i_we,
    input  reg_addr_t i_rd_addr,
    input  word_t     i_rd_data
);

    // x0 has no storage
    word_t r_regs [1 : 31];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 1; i < 32; i++) begin
                r_regs[i] <= '0;
            end
        end else if (i_we && (i_rd_addr != '0)) begin
            r_regs[i_rd_addr] <= i_rd_data;
        end
    end

    always_comb begin
        if (i_rs1_addr == '0) begin
            o_rs1_data = '0;
        end else begin
            o_rs1_data = r_regs[i_rs1_addr];
        end
    end

    always_comb begin
        if (i_rs2_addr == '0) begin
            o_rs2_data = '0;
        end else begin
            o_rs2_data = r_regs[i_rs2_addr];
        end
    end

endmodule

/* hdl/rv_exec_pkg.sv */
package rv_exec_pkg;

    ////////////////////////////////////////////////////////////
    // widths and reset values
    ////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;

    localparam logic [DATA_WIDTH - 1 : 0] RESET_PC = 32'h0000_0000;

    typedef logic [DATA_WIDTH - 1 : 0]     word_t;
    typedef logic [REG_ADDR_WIDTH - 1 : 0] reg_addr_t;

    ////////////////////////////////////////////////////////////
    // enums
    ////////////////////////////////////////////////////////////

    // compare and branch types give all ones when the condition holds
    typedef enum logic [4 : 0] {
        ALU_SLL  = 5'd0,
        ALU_SRL  = 5'd1,
        ALU_SRA  = 5'd2,
        ALU_ADD  = 5'd3,
        ALU_SUB  = 5'd4,
        ALU_XOR  = 5'd5,
        ALU_OR   = 5'd6,
        ALU_AND  = 5'd7,
        ALU_SLT  = 5'd8,
        ALU_SLTU = 5'd9,
        ALU_BEQ  = 5'd10,
        ALU_BNE  = 5'd11,
        ALU_BLT  = 5'd12,
        ALU_BGE  = 5'd13,
        ALU_BLTU = 5'd14,
        ALU_BGEU = 5'd15,
        ALU_JALR = 5'd16,
        ALU_NONE = 5'd17
    } alu_type_e;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6 : 0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_OP_IMM = 7'b0010011,
        OP_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [1 : 0] {
        JUMP_NONE   = 2'd0,
        JUMP_BRANCH = 2'd1,
        JUMP_JAL    = 2'd2,
        JUMP_JALR   = 2'd3
    } jump_kind_e;

endpackage
